// File: run.sh
#!/usr/bin/env bash
# Build and run the flash bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module flash_tb \
  -f vlog.f -o flash_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/flash_sim > sim.log 2>&1 \
  || { cat sim.log; echo "Simulation exited with an error"; exit 1; }

cat sim.log
grep -q "TEST FAIL" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

// File: source/flash_bridge.sv
// Wishbone to parallel NOR flash read bridge
// Memory and I/O page address mapping, page base register,
// wait-cycle read sequencer and byte lane assembly

`timescale 1ns/1ps

module flash_bridge
  import flash_pkg::*;
(
  input  logic                    wb_clk_i,
  input  logic                    reset_i,
  input  logic [WB_DATA_W-1:0]    wb_dat_i,
  output logic [WB_DATA_W-1:0]    wb_dat_o,
  input  logic [WB_ADDR_W:1]      wb_adr_i,
  input  logic                    wb_we_i,
  input  logic                    wb_tga_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_cyc_i,
  input  logic [1:0]              wb_sel_i,
  output logic                    wb_ack_o,

  output logic [FLASH_ADDR_W-1:0] flash_addr_o,
  input  logic [FLASH_DATA_W-1:0] flash_data_i,
  output logic                    flash_oe_n_o,
  output logic                    flash_we_n_o,
  output logic                    flash_ce_n_o,
  output logic                    flash_rst_n_o
);

  // Request decode
  logic      op;
  logic      rd_req;
  logic      wr_ack;
  logic      io_wr;
  logic      is_word;
  byte_sel_e sel;

  // Sequencer
  rd_state_e rd_state_q;
  rd_state_e rd_state_d;
  logic      high_phase;
  logic      high_start_q;
  logic      access_start;
  logic      data_valid;
  logic      low_done;
  logic      read_done;

  // Datapath
  logic [PAGE_BASE_W-1:0]  page_base_q;
  logic [FLASH_DATA_W-1:0] low_byte_q;
  logic                    byte_bit;

  assign op      = wb_stb_i & wb_cyc_i;
  assign rd_req  = op & ~wb_we_i;
  assign sel     = byte_sel_e'(wb_sel_i);
  assign is_word = (sel == SEL_WORD);

  // Writes never touch the flash, ack right away
  assign wr_ack = op & wb_we_i;
  // I/O tagged write loads the page base
  assign io_wr  = wr_ack & wb_tga_i;

  assign high_phase = (rd_state_q == RD_HIGH);

  // Address moves at a fresh read and at the low to high byte switch
  assign access_start = rd_req & ((rd_state_q == RD_IDLE) | high_start_q);

  flash_read_timer read_timer_i (
    .wb_clk_i        (wb_clk_i),
    .reset_i         (reset_i),
    .access_start_i  (access_start),
    .access_active_i (rd_req),
    .data_valid_o    (data_valid)
  );

  // First or only byte has been read
  assign low_done = rd_req & data_valid & ~high_phase;

  // Byte reads end on the first byte, word reads on the second
  always_comb begin
    if (is_word) begin
      read_done = rd_req & data_valid & high_phase;
    end else begin
      read_done = low_done;
    end
  end

  assign wb_ack_o = wr_ack | read_done;

  // Next state
  always_comb begin
    rd_state_d = rd_state_q;
    case (rd_state_q)
      // Idle and low share the first byte handling
      RD_IDLE, RD_LOW: begin
        if (!rd_req) begin
          rd_state_d = RD_IDLE;
        end else if (low_done) begin
          rd_state_d = is_word ? RD_HIGH : RD_IDLE;
        end else begin
          rd_state_d = RD_LOW;
        end
      end
      RD_HIGH: begin
        // Strobe dropped mid word, or high byte done
        if (!rd_req || data_valid) begin
          rd_state_d = RD_IDLE;
        end
      end
      default: rd_state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      rd_state_q   <= RD_IDLE;
      high_start_q <= 1'b0;
    end else begin
      rd_state_q   <= rd_state_d;
      // Marks the first cycle with the high byte address out
      high_start_q <= (rd_state_d == RD_HIGH) && (rd_state_q != RD_HIGH);
    end
  end

  // Page base register
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      page_base_q <= '0;
    end else if (io_wr) begin
      page_base_q <= wb_dat_i[PAGE_BASE_W-1:0];
    end
  end

  // Low byte of a word, held through the high byte access
  always_ff @(posedge wb_clk_i) begin
    if (low_done && is_word) begin
      low_byte_q <= flash_data_i;
    end
  end

  // Odd flash byte for the high lane and the second half of a word
  assign byte_bit = (sel == SEL_HIGH) | (is_word & high_phase);

  // Flash address mapping
  always_comb begin
    if (wb_tga_i) begin
      // Top half, 512 byte page picked by the base register
      flash_addr_o = {1'b1, page_base_q, wb_adr_i[PAGE_OFS_W:1], byte_bit};
    end else begin
      // Bottom 128 KB, direct
      flash_addr_o = {{(FLASH_ADDR_W-WB_ADDR_W-1){1'b0}}, wb_adr_i, byte_bit};
    end
  end

  // Lane assembly
  always_comb begin
    case (sel)
      SEL_HIGH: wb_dat_o = {flash_data_i, {FLASH_DATA_W{1'b0}}};
      SEL_WORD: wb_dat_o = {flash_data_i, low_byte_q};
      default:  wb_dat_o = {{FLASH_DATA_W{1'b0}}, flash_data_i};
    endcase
  end

  // Read only part, always selected
  assign flash_we_n_o  = 1'b1;
  assign flash_rst_n_o = 1'b1;
  assign flash_ce_n_o  = 1'b0;
  assign flash_oe_n_o  = ~op;

  // Ack only inside a live bus cycle
  ack_in_cycle: assert property (
    @(posedge wb_clk_i) disable iff (reset_i)
    wb_ack_o |-> (wb_stb_i && wb_cyc_i)
  ) else $error("flash_bridge ack without strobe and cycle");

  // Reads take at least one wait cycle each when the flash needs one
  read_ack_single: assert property (
    @(posedge wb_clk_i) disable iff (reset_i)
    ((FLASH_WAIT != 0) && wb_ack_o && !wb_we_i) |=> !(wb_ack_o && !wb_we_i)
  ) else $error("flash_bridge read ack held two cycles");

  // Second byte access only for full word requests
  high_only_word: assert property (
    @(posedge wb_clk_i) disable iff (reset_i)
    (rd_state_q == RD_HIGH && op) |-> is_word
  ) else $error("flash_bridge in RD_HIGH for a byte lane read");

endmodule

// File: source/flash_pkg.sv
// Flash bridge package
// Flash and Wishbone geometry, flash access wait count,
// byte lane select codes and read sequencer states

package flash_pkg;

  // Flash byte address and data widths
  localparam int FLASH_ADDR_W = 22;
  localparam int FLASH_DATA_W = 8;

  // Wishbone side, word addressed over bits 16..1
  localparam int WB_DATA_W = 16;
  localparam int WB_ADDR_W = 16;

  // I/O page window
  localparam int PAGE_BASE_W = 12;
  localparam int PAGE_OFS_W  = 8;

  // Flash access time in clock cycles, zero allowed
  localparam int FLASH_WAIT = 2;

  // Wait counter width, at least one bit even for a zero wait
  localparam int WAIT_CNT_W = (FLASH_WAIT > 0) ? $clog2(FLASH_WAIT + 1) : 1;

  // Read sequencer
  typedef enum logic [1:0] {
    RD_IDLE = 2'd0,
    // First or only byte on the pads
    RD_LOW  = 2'd1,
    // Second byte of a word on the pads
    RD_HIGH = 2'd2
  } rd_state_e;

  // Wishbone byte lane selects, same encoding as wb_sel_i
  typedef enum logic [1:0] {
    SEL_LOW  = 2'b01,
    SEL_HIGH = 2'b10,
    SEL_WORD = 2'b11
  } byte_sel_e;

endpackage

// File: source/flash_read_timer.sv
// Flash access timer
// Counts wait cycles after each flash address change and
// flags when the byte on the pads can be sampled

`timescale 1ns/1ps

module flash_read_timer
  import flash_pkg::*;
(
  input  logic wb_clk_i,
  input  logic reset_i,
  // Flash address changes this cycle
  input  logic access_start_i,
  // A read is still in progress
  input  logic access_active_i,
  // Byte on the flash data pads is valid
  output logic data_valid_o
);

  logic [WAIT_CNT_W-1:0] count_q;
  logic [WAIT_CNT_W-1:0] count_d;
  logic [WAIT_CNT_W-1:0] remaining;

  // A start restarts the wait from the full count
  assign remaining = access_start_i ? WAIT_CNT_W'(FLASH_WAIT) : count_q;

  // Zero wait gives validity in the start cycle itself
  assign data_valid_o = (remaining == '0);

  // Next count
  always_comb begin
    count_d = remaining;
    // Only burn wait cycles while the bus keeps the read open
    if (access_active_i && (remaining != '0)) begin
      count_d = remaining - 1'b1;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else begin
      count_q <= count_d;
    end
  end

  // Counter stays inside the programmed access time
  count_in_range: assert property (
    @(posedge wb_clk_i) disable iff (reset_i)
    count_q <= WAIT_CNT_W'(FLASH_WAIT)
  ) else $error("flash_read_timer count %0d above FLASH_WAIT", count_q);

endmodule

// File: source/flash_top.sv
// Boot flash bridge top level
// Wishbone slave and NOR flash pad boundary

`timescale 1ns/1ps

module flash_top
  import flash_pkg::*;
(
  // Wishbone slave
  input  logic                    wb_clk_i,
  input  logic                    reset_i,
  input  logic [WB_DATA_W-1:0]    wb_dat_i,
  output logic [WB_DATA_W-1:0]    wb_dat_o,
  // Word address
  input  logic [WB_ADDR_W:1]      wb_adr_i,
  input  logic                    wb_we_i,
  // High for I/O space cycles
  input  logic                    wb_tga_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_cyc_i,
  input  logic [1:0]              wb_sel_i,
  output logic                    wb_ack_o,

  // Flash pads
  output logic [FLASH_ADDR_W-1:0] flash_addr_o,
  input  logic [FLASH_DATA_W-1:0] flash_data_i,
  output logic                    flash_we_n_o,
  output logic                    flash_oe_n_o,
  output logic                    flash_ce_n_o,
  output logic                    flash_rst_n_o
);

  // Bridge side nets
  logic [WB_DATA_W-1:0]    bridge_dat;
  logic                    bridge_ack;
  logic [FLASH_ADDR_W-1:0] bridge_addr;
  logic                    bridge_we_n;
  logic                    bridge_oe_n;
  logic                    bridge_ce_n;
  logic                    bridge_rst_n;

  flash_bridge flash_bridge_i (
    .wb_clk_i      (wb_clk_i),
    .reset_i       (reset_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (bridge_dat),
    .wb_adr_i      (wb_adr_i),
    .wb_we_i       (wb_we_i),
    .wb_tga_i      (wb_tga_i),
    .wb_stb_i      (wb_stb_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_sel_i      (wb_sel_i),
    .wb_ack_o      (bridge_ack),
    .flash_addr_o  (bridge_addr),
    .flash_data_i  (flash_data_i),
    .flash_oe_n_o  (bridge_oe_n),
    .flash_we_n_o  (bridge_we_n),
    .flash_ce_n_o  (bridge_ce_n),
    .flash_rst_n_o (bridge_rst_n)
  );

  // Bus side
  assign wb_dat_o = bridge_dat;
  assign wb_ack_o = bridge_ack;

  // Pad side
  assign flash_addr_o  = bridge_addr;
  assign flash_we_n_o  = bridge_we_n;
  assign flash_oe_n_o  = bridge_oe_n;
  assign flash_ce_n_o  = bridge_ce_n;
  assign flash_rst_n_o = bridge_rst_n;

endmodule

// File: test/flash_model.sv
// Behavioural read-only parallel NOR flash
// Byte data follows an address formula and stays unknown until the access
// time has passed, plus checks on the pad controls

`timescale 1ns/1ps

module flash_model
  import flash_pkg::*;
(
  input  logic                    clk_i,
  input  logic [FLASH_ADDR_W-1:0] flash_addr_i,
  output logic [FLASH_DATA_W-1:0] flash_data_o,
  input  logic                    flash_we_n_i,
  input  logic                    flash_oe_n_i,
  input  logic                    flash_ce_n_i,
  input  logic                    flash_rst_n_i,
  output int                      pad_errors_o
);

  // Address seen at the last edge and cycles spent on it
  logic [FLASH_ADDR_W-1:0] addr_q = '0;
  int                      age_q = 0;
  logic                    settled;
  int                      err_count = 0;

  // Cell contents, a mix of all address bytes
  function automatic logic [FLASH_DATA_W-1:0] cell_value(
    input logic [FLASH_ADDR_W-1:0] addr
  );
    return addr[7:0] ^ addr[15:8] ^ {2'b00, addr[21:16]};
  endfunction

  // Restart the access time on every address change
  always @(posedge clk_i) begin
    if (flash_addr_i !== addr_q) begin
      addr_q <= flash_addr_i;
      age_q  <= 1;
    end else if (age_q < FLASH_WAIT) begin
      age_q <= age_q + 1;
    end
  end

  // Zero wait part answers in the same cycle
  assign settled = (FLASH_WAIT == 0) ||
                   ((flash_addr_i === addr_q) && (age_q >= FLASH_WAIT));

  assign flash_data_o = (settled && !flash_oe_n_i) ? cell_value(flash_addr_i) : 'x;

  // Pads sampled mid cycle
  always @(negedge clk_i) begin
    if (flash_we_n_i !== 1'b1) begin
      err_count = err_count + 1;
      $display("Flash write enable was driven low at %0t", $time);
    end
    if (flash_rst_n_i !== 1'b1) begin
      err_count = err_count + 1;
      $display("Flash reset pad was driven low at %0t", $time);
    end
    if (flash_oe_n_i === 1'b0 && flash_ce_n_i !== 1'b0) begin
      err_count = err_count + 1;
      $display("Flash output enable low while chip enable high at %0t", $time);
    end
  end

  assign pad_errors_o = err_count;

endmodule

// File: test/flash_tb.sv
// Flash bridge testbench
// Clock and reset, Wishbone master tasks, compare tasks and directed tests
// for byte, word, page window, write and back-to-back cycles

`timescale 1ns/1ps

module flash_tb
  import flash_pkg::*;
();

  logic                    wb_clk_i;
  logic                    reset_i;
  logic [WB_DATA_W-1:0]    wb_dat_i;
  logic [WB_DATA_W-1:0]    wb_dat_o;
  logic [WB_ADDR_W:1]      wb_adr_i;
  logic                    wb_we_i;
  logic                    wb_tga_i;
  logic                    wb_stb_i;
  logic                    wb_cyc_i;
  logic [1:0]              wb_sel_i;
  logic                    wb_ack_o;
  logic [FLASH_ADDR_W-1:0] flash_addr_o;
  logic [FLASH_DATA_W-1:0] flash_data_i;
  logic                    flash_we_n_o;
  logic                    flash_oe_n_o;
  logic                    flash_ce_n_o;
  logic                    flash_rst_n_o;

  // Error counts by kind
  int data_errors = 0;
  int cycle_errors = 0;
  int lane_errors = 0;
  int level_errors = 0;
  int timeout_errors = 0;
  int pad_errors;
  int ack_count = 0;
  int seed = 12413;

  // Expected page base as set by the I/O writes
  logic [PAGE_BASE_W-1:0] page_base = '0;

  flash_top flash_top_i (
    .wb_clk_i      (wb_clk_i),
    .reset_i       (reset_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_adr_i      (wb_adr_i),
    .wb_we_i       (wb_we_i),
    .wb_tga_i      (wb_tga_i),
    .wb_stb_i      (wb_stb_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_sel_i      (wb_sel_i),
    .wb_ack_o      (wb_ack_o),
    .flash_addr_o  (flash_addr_o),
    .flash_data_i  (flash_data_i),
    .flash_we_n_o  (flash_we_n_o),
    .flash_oe_n_o  (flash_oe_n_o),
    .flash_ce_n_o  (flash_ce_n_o),
    .flash_rst_n_o (flash_rst_n_o)
  );

  flash_model flash_model_i (
    .clk_i         (wb_clk_i),
    .flash_addr_i  (flash_addr_o),
    .flash_data_o  (flash_data_i),
    .flash_we_n_i  (flash_we_n_o),
    .flash_oe_n_i  (flash_oe_n_o),
    .flash_ce_n_i  (flash_ce_n_o),
    .flash_rst_n_i (flash_rst_n_o),
    .pad_errors_o  (pad_errors)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #50 wb_clk_i = ~wb_clk_i;
  end

  // Every acknowledge pulse sampled mid cycle
  always @(negedge wb_clk_i) begin
    if (wb_ack_o === 1'b1) begin
      ack_count++;
    end
  end

  function automatic logic [WB_DATA_W-1:0] random_word();
    logic [31:0] r;
    r = $random(seed);
    return r[WB_DATA_W-1:0];
  endfunction

  // Expected flash contents
  function automatic logic [FLASH_DATA_W-1:0] expected_byte(
    input logic [FLASH_ADDR_W-1:0] a
  );
    return a[7:0] ^ a[15:8] ^ {2'b00, a[21:16]};
  endfunction

  // Even flash byte address of a word with I/O cycles in the top half
  function automatic logic [FLASH_ADDR_W-1:0] even_addr(
    input logic tga,
    input logic [WB_ADDR_W:1] adr,
    input logic [PAGE_BASE_W-1:0] base
  );
    logic [FLASH_ADDR_W-1:0] a;
    if (tga) begin
      a = FLASH_ADDR_W'((1 << (FLASH_ADDR_W - 1)) + base * 512 +
                        adr[PAGE_OFS_W:1] * 2);
    end else begin
      a = FLASH_ADDR_W'(adr * 2);
    end
    return a;
  endfunction

  task automatic check_data(input string name, input logic [WB_DATA_W-1:0] got,
                            input logic [WB_DATA_W-1:0] exp);
    if (got !== exp) begin
      data_errors++;
      $display("** Error: %s got 0x%04h expected 0x%04h", name, got, exp);
    end
  endtask

  task automatic check_cycles(input string name, input int got, input int exp);
    if (got != exp) begin
      cycle_errors++;
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_state(input string name, input byte_sel_e got, input byte_sel_e exp);
    if (got !== exp) begin
      lane_errors++;
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      level_errors++;
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  // Drop the request and leave one idle cycle
  task automatic bus_idle();
    wb_stb_i <= 1'b0;
    wb_cyc_i <= 1'b0;
    wb_we_i  <= 1'b0;
    @(posedge wb_clk_i);
  endtask

  // Count cycles to the ack and capture data and the byte bit there
  task automatic wait_ack(output int cycles, output logic [WB_DATA_W-1:0] data,
                          output byte_sel_e lane);
    int   limit;
    logic acked;
    limit  = 4 * FLASH_WAIT + 16;
    cycles = 0;
    acked  = 1'b0;
    data   = 'x;
    lane   = SEL_LOW;
    while (!acked && cycles <= limit) begin
      @(negedge wb_clk_i);
      if (wb_ack_o === 1'b1) begin
        acked = 1'b1;
        data  = wb_dat_o;
        lane  = flash_addr_o[0] ? SEL_HIGH : SEL_LOW;
      end else begin
        cycles++;
      end
    end
    if (!acked) begin
      timeout_errors++;
      $display("Timeout, no acknowledge within %0d cycles at %0t", limit, $time);
    end
    // Return on the edge that ends the ack cycle
    @(posedge wb_clk_i);
  endtask

  task automatic wb_write(input logic tga, input logic [WB_ADDR_W:1] adr,
                          input logic [WB_DATA_W-1:0] data, output int cycles);
    logic [WB_DATA_W-1:0] unused_data;
    byte_sel_e            unused_lane;
    wb_adr_i <= adr;
    wb_dat_i <= data;
    wb_we_i  <= 1'b1;
    wb_tga_i <= tga;
    wb_sel_i <= SEL_WORD;
    wb_stb_i <= 1'b1;
    wb_cyc_i <= 1'b1;
    wait_ack(cycles, unused_data, unused_lane);
  endtask

  task automatic wb_read(input logic tga, input logic [WB_ADDR_W:1] adr,
                         input byte_sel_e sel, output logic [WB_DATA_W-1:0] data,
                         output int cycles, output byte_sel_e lane);
    wb_adr_i <= adr;
    wb_we_i  <= 1'b0;
    wb_tga_i <= tga;
    wb_sel_i <= sel;
    wb_stb_i <= 1'b1;
    wb_cyc_i <= 1'b1;
    wait_ack(cycles, data, lane);
  endtask

  // One read with data, latency and last byte bit checked
  task automatic read_and_check(input logic tga, input logic [WB_ADDR_W:1] adr,
                                input byte_sel_e sel);
    logic [FLASH_ADDR_W-1:0] a;
    logic [WB_DATA_W-1:0]    data;
    logic [WB_DATA_W-1:0]    exp_data;
    int                      cycles;
    int                      exp_cycles;
    byte_sel_e               lane;
    byte_sel_e               exp_lane;
    a = even_addr(tga, adr, page_base);
    case (sel)
      SEL_LOW: begin
        exp_data   = {8'h00, expected_byte(a)};
        exp_cycles = FLASH_WAIT;
        exp_lane   = SEL_LOW;
      end
      SEL_HIGH: begin
        exp_data   = {expected_byte({a[FLASH_ADDR_W-1:1], 1'b1}), 8'h00};
        exp_cycles = FLASH_WAIT;
        exp_lane   = SEL_HIGH;
      end
      default: begin
        exp_data   = {expected_byte({a[FLASH_ADDR_W-1:1], 1'b1}), expected_byte(a)};
        exp_cycles = 2 * FLASH_WAIT + 1;
        exp_lane   = SEL_HIGH;
      end
    endcase
    wb_read(tga, adr, sel, data, cycles, lane);
    check_data($sformatf("wb_dat_o flash 0x%06h sel %0d", a, sel), data, exp_data);
    check_cycles($sformatf("wb_ack_o latency flash 0x%06h", a), cycles, exp_cycles);
    check_state($sformatf("flash_addr_o byte lane 0x%06h", a), lane, exp_lane);
  endtask

  task automatic test_reset_levels();
    @(negedge wb_clk_i);
    check_level("wb_ack_o", wb_ack_o, 1'b0);
    check_level("flash_we_n_o", flash_we_n_o, 1'b1);
    check_level("flash_rst_n_o", flash_rst_n_o, 1'b1);
    check_level("flash_ce_n_o", flash_ce_n_o, 1'b0);
    check_level("flash_oe_n_o", flash_oe_n_o, 1'b1);
    @(posedge wb_clk_i);
  endtask

  task automatic test_mem_reads(input byte_sel_e sel);
    logic [WB_ADDR_W:1] adr;
    repeat (8) begin
      adr = random_word();
      read_and_check(1'b0, adr, sel);
      bus_idle();
    end
    // Last word of the window
    read_and_check(1'b0, '1, sel);
    bus_idle();
  endtask

  task automatic test_page_window();
    logic [WB_DATA_W-1:0] data;
    int                   cycles;
    data = random_word();
    wb_write(1'b1, random_word(), data, cycles);
    check_cycles("wb_ack_o write latency", cycles, 0);
    bus_idle();
    page_base = data[PAGE_BASE_W-1:0];
    repeat (4) begin
      read_and_check(1'b1, random_word(), SEL_LOW);
      bus_idle();
      read_and_check(1'b1, random_word(), SEL_HIGH);
      bus_idle();
      read_and_check(1'b1, random_word(), SEL_WORD);
      bus_idle();
    end
    // Memory space ignores the base
    read_and_check(1'b0, random_word(), SEL_WORD);
    bus_idle();
  endtask

  task automatic test_mem_write();
    int cycles;
    wb_write(1'b0, random_word(), random_word(), cycles);
    check_cycles("wb_ack_o write latency", cycles, 0);
    bus_idle();
    // Base must still be the old one
    read_and_check(1'b1, random_word(), SEL_WORD);
    bus_idle();
  endtask

  task automatic test_back_to_back();
    int start_count;
    start_count = ack_count;
    read_and_check(1'b0, random_word(), SEL_WORD);
    read_and_check(1'b0, random_word(), SEL_HIGH);
    read_and_check(1'b1, random_word(), SEL_WORD);
    read_and_check(1'b0, random_word(), SEL_LOW);
    read_and_check(1'b1, random_word(), SEL_HIGH);
    bus_idle();
    check_cycles("wb_ack_o pulse count", ack_count - start_count, 5);
  endtask

  initial begin
    int total;
    reset_i  <= 1'b1;
    wb_dat_i <= '0;
    wb_adr_i <= '0;
    wb_we_i  <= 1'b0;
    wb_tga_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_cyc_i <= 1'b0;
    wb_sel_i <= SEL_WORD;
    repeat (10) @(posedge wb_clk_i);
    reset_i <= 1'b0;
    @(posedge wb_clk_i);

    test_reset_levels();
    test_mem_reads(SEL_LOW);
    test_mem_reads(SEL_HIGH);
    test_mem_reads(SEL_WORD);
    test_page_window();
    test_mem_write();
    test_back_to_back();

    total = data_errors + cycle_errors + lane_errors + level_errors +
            pad_errors + timeout_errors;
    $display("Errors: data %0d latency %0d lane %0d level %0d pad %0d timeout %0d",
             data_errors, cycle_errors, lane_errors, level_errors, pad_errors,
             timeout_errors);
    if (total == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: vlog.f
source/flash_pkg.sv
source/flash_read_timer.sv
source/flash_bridge.sv
source/flash_top.sv
test/flash_model.sv
test/flash_tb.sv
